// ==== design/hackPkg.sv ====
package hackPkg;

	typedef logic [15:0] word;			// HACK machine word

	// Memory depths in words
	localparam int ramWords = 3840;			// Data RAM 0 to 3839
	localparam int romWords = 256;			// Instruction ROM

	// I/O register addresses
	localparam logic [14:0] ledAddr = 15'd4096;	// LED, 2 bits kept
	localparam logic [14:0] butAddr = 15'd4097;	// Buttons, read only
	localparam logic [14:0] debugAddr = 15'd4107;	// DEBUG0

	// Program image for the ROM
	localparam romFile = "program.hex";		// One hex word per line

	// CPU to memory map, no handshake
	typedef struct packed {
		logic [14:0] addr;			// Word address, taken from A
		word wdata;				// ALU result, outM
		logic write;				// writeM
	} dataBus;

endpackage

// ==== design/isaPkg.sv ====
package isaPkg;

	// Bit 15 of the instruction
	typedef enum logic {
		instA = 1'b0,				// Load constant into A
		instC = 1'b1				// Compute, store, jump
	} instKind;

	// j1 j2 j3 of the C-instruction
	typedef enum logic [2:0] {
		jmpNone = 3'b000,			// Never
		jmpGt = 3'b001,				// out > 0
		jmpEq = 3'b010,				// out == 0
		jmpGe = 3'b011,				// out >= 0
		jmpLt = 3'b100,				// out < 0
		jmpNe = 3'b101,				// out != 0
		jmpLe = 3'b110,				// out <= 0
		jmpAlways = 3'b111			// Unconditional
	} jumpCond;

	// Same layout as instruction bits 12 to 0
	typedef struct packed {
		logic useM;				// a bit, y from M instead of A
		logic zx;				// Zero x
		logic nx;				// Invert x
		logic zy;				// Zero y
		logic ny;				// Invert y
		logic f;				// 1 add, 0 and
		logic no;				// Invert result
		logic destA;				// d1
		logic destD;				// d2
		logic destM;				// d3, memory write
		jumpCond jump;				// j1 j2 j3
	} cFields;

	function automatic instKind kindOf(logic [15:0] inst);
		return instKind'(inst[15]);
	endfunction

	function automatic cFields decodeC(logic [15:0] inst);
		return cFields'(inst[12:0]);		// Bits 14 and 13 ignored
	endfunction

endpackage

// ==== design/hackCpu.sv ====
`timescale 1ns/1ns

module hackCpu (
	input logic clk,
	input logic arstN,
	input hackPkg::word inM,			// Read data from memory map
	output hackPkg::dataBus bus			// Address, write data, write strobe
);
	import hackPkg::*;
	import isaPkg::*;

	// Instruction ROM
	word rom [romWords];				// Loaded once, never written
	word inst;					// Current instruction
	instKind kind;					// A or C
	cFields cf;					// Decoded C fields

	// Architectural registers
	word aReg;					// Address and constant register
	word dReg;					// Data register
	word pc;					// Program counter

	// ALU datapath
	word xIn;					// D
	word yIn;					// A or M
	word xZ;
	word xN;
	word yZ;
	word yN;
	word fOut;					// Add or and
	word aluOut;					// outM
	logic zr;					// Result is zero
	logic ng;					// Result is negative
	logic isC;
	logic takeJump;

	initial begin
		$readmemh(romFile, rom);		// Program image
	end

	assign inst = rom[pc[$clog2(romWords)-1:0]];	// Async fetch
	assign kind = kindOf(inst);
	assign cf = decodeC(inst);
	assign isC = (kind == instC);

	// HACK ALU
	assign xIn = dReg;
	assign yIn = cf.useM ? inM : aReg;		// a bit picks M
	assign xZ = cf.zx ? '0 : xIn;
	assign xN = cf.nx ? ~xZ : xZ;
	assign yZ = cf.zy ? '0 : yIn;
	assign yN = cf.ny ? ~yZ : yZ;
	assign fOut = cf.f ? (xN + yN) : (xN & yN);
	assign aluOut = cf.no ? ~fOut : fOut;
	assign zr = (aluOut == '0);
	assign ng = aluOut[15];				// Two's complement sign

	// Jump condition against flags
	always_comb begin
		case (cf.jump)
			jmpNone: takeJump = 1'b0;
			jmpGt: takeJump = !zr && !ng;
			jmpEq: takeJump = zr;
			jmpGe: takeJump = !ng;
			jmpLt: takeJump = ng;
			jmpNe: takeJump = !zr;
			jmpLe: takeJump = zr || ng;
			jmpAlways: takeJump = 1'b1;
			default: takeJump = 1'b0;
		endcase
	end

	// A register
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			aReg <= '0;
		end else if (!isC) begin
			aReg <= inst;				// @value
		end else if (cf.destA) begin
			aReg <= aluOut;
		end
	end

	// D register
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			dReg <= '0;
		end else if (isC && cf.destD) begin
			dReg <= aluOut;
		end
	end

	// PC, one instruction per cycle
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
		end else if (isC && takeJump) begin
			pc <= aReg;				// Target is old A
		end else begin
			pc <= pc + 16'd1;
		end
	end

	// Memory side, write lands with the PC update
	assign bus.addr = aReg[14:0];			// addressM
	assign bus.wdata = aluOut;			// outM
	assign bus.write = isC && cf.destM;		// writeM

endmodule

// ==== design/dataRam.sv ====
`timescale 1ns/1ns

module dataRam (
	input logic clk,
	input logic [11:0] addr,			// Low address bits
	input hackPkg::word wdata,			// Write data from CPU
	input logic load,				// Write strobe, already decoded
	output hackPkg::word rdata			// Combinational read
);
	import hackPkg::*;

	word mem [ramWords];				// 3840 words, no reset

	assign rdata = mem[addr];			// Only used in range

	// Clocked write
	always_ff @(posedge clk) begin
		if (load) begin
			mem[addr] <= wdata;
		end
	end

endmodule

// ==== design/ioRegs.sv ====
`timescale 1ns/1ns

module ioRegs (
	input logic clk,
	input logic arstN,
	input hackPkg::word wdata,			// Write data from CPU
	input logic ledLoad,				// Write to 4096
	input logic debugLoad,				// Write to 4107
	input logic [1:0] but,				// Button pins
	output hackPkg::word ledData,			// LED read value
	output hackPkg::word butData,			// Button read value
	output hackPkg::word debugData			// DEBUG0 read value
);
	import hackPkg::*;

	logic [1:0] ledReg;				// Only 2 LEDs
	logic [1:0] butReg;				// Sampled pins
	word debugReg;					// DEBUG0

	// LED register
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			ledReg <= '0;
		end else if (ledLoad) begin
			ledReg <= wdata[1:0];			// Upper bits dropped
		end
	end

	// Button register, loads every cycle
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			butReg <= '0;
		end else begin
			butReg <= but;
		end
	end

	// DEBUG0 register
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			debugReg <= '0;
		end else if (debugLoad) begin
			debugReg <= wdata;
		end
	end

	// Read values, zero extended
	assign ledData = {14'd0, ledReg};
	assign butData = {14'd0, butReg};
	assign debugData = debugReg;

endmodule

// ==== design/memoryMap.sv ====
`timescale 1ns/1ns

module memoryMap (
	input hackPkg::dataBus bus,			// From CPU
	input hackPkg::word ramData,			// RAM read
	input hackPkg::word ledData,			// 4096
	input hackPkg::word butData,			// 4097
	input hackPkg::word debugData,			// 4107
	output logic ramLoad,				// RAM write strobe
	output logic ledLoad,				// LED write strobe
	output logic debugLoad,				// DEBUG0 write strobe
	output hackPkg::word inM			// Back to CPU
);
	import hackPkg::*;

	logic inRam;					// 0 to 3839
	logic isLed;
	logic isBut;
	logic isDebug;

	// Address decode
	assign inRam = (bus.addr < 15'(ramWords));
	assign isLed = (bus.addr == ledAddr);
	assign isBut = (bus.addr == butAddr);
	assign isDebug = (bus.addr == debugAddr);

	// Write strobes, buttons have none
	assign ramLoad = bus.write && inRam;
	assign ledLoad = bus.write && isLed;
	assign debugLoad = bus.write && isDebug;

	// Read merge, decodes are disjoint
	always_comb begin
		if (inRam) begin
			inM = ramData;
		end else if (isLed) begin
			inM = ledData;
		end else if (isBut) begin
			inM = butData;
		end else if (isDebug) begin
			inM = debugData;
		end else begin
			inM = '0;				// Reserved and unmapped
		end
	end

endmodule

// ==== design/hackTop.sv ====
`timescale 1ns/1ns

module hackTop (
	input logic clk,				// Single system clock
	input logic arstN,
	input logic [1:0] but,				// Button pins
	output logic [1:0] led,				// LED pins
	output hackPkg::word debug			// DEBUG0 for observation
);
	import hackPkg::*;

	dataBus cpuBus;					// addr, wdata, write
	word inM;					// Merged read data
	word ramData;
	word ledData;
	word butData;
	word debugData;
	logic ramLoad;
	logic ledLoad;
	logic debugLoad;

	// CPU with A, D, PC, ALU and ROM
	hackCpu cpu_i (
		.clk(clk),
		.arstN(arstN),
		.inM(inM),
		.bus(cpuBus)
	);

	// Decode and read merge
	memoryMap map_i (
		.bus(cpuBus),
		.ramData(ramData),
		.ledData(ledData),
		.butData(butData),
		.debugData(debugData),
		.ramLoad(ramLoad),
		.ledLoad(ledLoad),
		.debugLoad(debugLoad),
		.inM(inM)
	);

	// 3840 x 16 data RAM
	dataRam ram_i (
		.clk(clk),
		.addr(cpuBus.addr[11:0]),
		.wdata(cpuBus.wdata),
		.load(ramLoad),
		.rdata(ramData)
	);

	// LED, buttons, DEBUG0
	ioRegs io_i (
		.clk(clk),
		.arstN(arstN),
		.wdata(cpuBus.wdata),
		.ledLoad(ledLoad),
		.debugLoad(debugLoad),
		.but(but),
		.ledData(ledData),
		.butData(butData),
		.debugData(debugData)
	);

	assign led = ledData[1:0];			// 2 LED pins
	assign debug = debugData;

endmodule

// ==== test/hackTop_sva.sv ====
`timescale 1ns/1ns

module hackTop_sva (
	input logic clk,
	input logic arstN,
	input logic ramLoad,				// From map_i
	input logic ledLoad,
	input logic debugLoad,
	input logic busWrite,				// cpuBus.write
	input logic [1:0] led
);

	int failCount = 0;				// Read by the testbench

	// Decodes are disjoint, so at most one strobe
	strobeOneHot: assert property (@(posedge clk) disable iff (!arstN)
		$onehot0({ramLoad, ledLoad, debugLoad}))
		else begin
			failCount++;
			$error("More than one write strobe asserted in one cycle");
		end

	// PC held at 0, an A-instruction
	noWriteInReset: assert property (@(negedge clk) !arstN |-> !busWrite)
		else begin
			failCount++;
			$error("bus.write asserted while arstN is low");
		end

	ledKnown: assert property (@(posedge clk) arstN |-> !$isunknown(led))
		else begin
			failCount++;
			$error("led is unknown after reset");
		end

endmodule

// ==== test/hackChecker.sv ====
`timescale 1ns/1ns

module hackChecker (
	input logic clk,
	input logic arstN,
	input logic [1:0] led,				// DUT LED pins
	input hackPkg::word debug			// DUT DEBUG0
);
	import hackPkg::*;

	localparam int settleCycles = 40;		// Two loop passes and more

	int errorCount = 0;
	int checkCount = 0;
	logic wasReset = 1'b1;				// Previous negedge was in reset

	// Value the program leaves in DEBUG0
	function automatic word expectedDebug(input logic [1:0] b);
		if (b == 2'd3) begin
			return 16'hFFFF;			// RAM[16] - 3 == 0 path
		end
		return {14'd0, b} + 16'd5;
	endfunction

	task automatic reportValue(input string name, input string what, input word expVal,
			input word actVal);
		errorCount++;
		$display("ERROR %s: %s expected %h actual %h at %0t", name, what, expVal, actVal, $time);
	endtask

	// Reset state, also the first cycle after release
	always @(negedge clk) begin
		if (!arstN || wasReset) begin
			checkCount++;
			if (led !== 2'b00) begin
				reportValue("reset", "led", 16'd0, {14'd0, led});
			end
			if (debug !== 16'd0) begin
				reportValue("reset", "debug", 16'd0, debug);
			end
		end
		wasReset = !arstN;
	end

	// Wait for settling, then hold stable until the buttons move
	task automatic checkEntry(input string name, input logic [1:0] butVal, input int holdCycles);
		logic [1:0] expLed;
		word expDebug;
		int waited;
		bit settled;
		bit stable;
		expLed = butVal;				// LED mirrors buttons
		expDebug = expectedDebug(butVal);
		waited = 0;
		settled = 1'b0;
		stable = 1'b1;
		while (!settled && waited < settleCycles) begin
			@(negedge clk);				// Away from driving edge
			waited++;
			settled = (led === expLed) && (debug === expDebug);
		end
		checkCount++;
		if (!settled) begin
			if (led !== expLed) begin
				reportValue(name, "led", {14'd0, expLed}, {14'd0, led});
			end
			if (debug !== expDebug) begin
				reportValue(name, "debug", expDebug, debug);
			end
		end
		while (waited < holdCycles) begin
			@(negedge clk);
			waited++;
			if (settled && stable && (led !== expLed || debug !== expDebug)) begin
				stable = 1'b0;				// One report per entry
				if (led !== expLed) begin
					reportValue(name, "led after settling", {14'd0, expLed}, {14'd0, led});
				end else begin
					reportValue(name, "debug after settling", expDebug, debug);
				end
			end
		end
		if (settled) begin
			checkCount++;
		end
	endtask

endmodule

// ==== test/hackTb.sv ====
`timescale 1ns/1ns

module hackTb;
	import hackPkg::*;

	localparam int clkPeriod = 100;			// ns
	localparam int resetCycles = 8;			// Initial reset length
	localparam int numTests = 12;			// Table entries
	localparam int holdCycles = 64;			// Cycles per entry
	localparam int pulseCycles = 4;			// Mid-run reset width
	localparam int watchdogNs = (resetCycles + numTests * holdCycles + holdCycles) * clkPeriod;

	// One row of the stimulus table
	typedef struct packed {
		logic [1:0] but;			// Button pins
		logic [7:0] hold;			// Cycles to hold
		logic midReset;				// Pulse arstN first
	} stimEntry;

	logic clk;
	logic arstN;
	logic [1:0] but;
	logic [1:0] led;
	word debug;

	string stimName [numTests];			// Names for error lines
	stimEntry stimTable [numTests];

	hackTop dut_i (
		.clk(clk),
		.arstN(arstN),
		.but(but),
		.led(led),
		.debug(debug)
	);

	// Compares DUT outputs against the program's rules
	hackChecker chk_i (
		.clk(clk),
		.arstN(arstN),
		.led(led),
		.debug(debug)
	);

	bind hackTop hackTop_sva sva_i (
		.clk(clk),
		.arstN(arstN),
		.ramLoad(ramLoad),
		.ledLoad(ledLoad),
		.debugLoad(debugLoad),
		.busWrite(cpuBus.write),
		.led(led)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;	// 10 MHz
	end

	task automatic setEntry(input int i, input string name, input logic [1:0] b,
			input logic mid);
		stimName[i] = name;
		stimTable[i].but = b;
		stimTable[i].hold = 8'(holdCycles);
		stimTable[i].midReset = mid;
	endtask

	task automatic fillTable();
		setEntry(0, "btn0", 2'd0, 1'b0);		// 0 + 5
		setEntry(1, "btn1", 2'd1, 1'b0);
		setEntry(2, "btn2", 2'd2, 1'b0);
		setEntry(3, "btn3Special", 2'd3, 1'b0);	// JEQ taken, -1
		setEntry(4, "btn1Back", 2'd1, 1'b0);
		setEntry(5, "btn3Again", 2'd3, 1'b0);
		setEntry(6, "resetHold3", 2'd3, 1'b1);	// Same buttons, reset between
		setEntry(7, "btn0Again", 2'd0, 1'b0);
		setEntry(8, "btn2Again", 2'd2, 1'b0);
		setEntry(9, "resetHold2", 2'd2, 1'b1);
		setEntry(10, "btn3Last", 2'd3, 1'b0);
		setEntry(11, "btn0Last", 2'd0, 1'b0);
	endtask

	// Drive one row, then let the checker own the hold time
	task automatic applyEntry(input int i);
		stimEntry e;
		int holdLeft;
		e = stimTable[i];
		holdLeft = int'(e.hold);
		@(posedge clk);
		but <= e.but;
		if (e.midReset) begin
			arstN <= 1'b0;				// Outputs clear at once
			repeat (pulseCycles) @(posedge clk);
			arstN <= 1'b1;
			holdLeft = holdLeft - pulseCycles;	// Keep entry length fixed
		end
		chk_i.checkEntry(stimName[i], e.but, holdLeft);
	endtask

	// Watchdog
	initial begin
		#(watchdogNs);
		$display("Watchdog: simulation ran past %0d ns without finishing the table", watchdogNs);
		$display("Errors found");
		$finish;
	end

	initial begin
		int totalErrors;
		arstN = 1'b0;
		but = 2'b00;
		fillTable();
		repeat (resetCycles) @(posedge clk);
		arstN <= 1'b1;
		for (int i = 0; i < numTests; i++) begin
			applyEntry(i);
		end
		@(posedge clk);
		totalErrors = chk_i.errorCount + dut_i.sva_i.failCount;
		$display("Closing: %0d checker errors, %0d assertion failures, %0d checks",
			chk_i.errorCount, dut_i.sva_i.failCount, chk_i.checkCount);
		if (totalErrors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== program.hex ====
// HACK program image for the instruction ROM
// One 16-bit instruction per line in hex, then its assembly form
1001	// @4097 button register
FC10	// D=M
1000	// @4096 LED register
E308	// M=D
0010	// @16
E308	// M=D, keep buttons in RAM
0003	// @3
E4D0	// D=D-A
0012	// @18 special case
E302	// D;JEQ
0010	// @16
FC10	// D=M, reload from RAM
0005	// @5
E090	// D=D+A
100B	// @4107 DEBUG0
E308	// M=D
0000	// @0
EA87	// 0;JMP
100B	// @4107 DEBUG0
EE88	// M=-1
0000	// @0
EA87	// 0;JMP

// ==== src.f ====
design/hackPkg.sv
design/isaPkg.sv
design/hackCpu.sv
design/dataRam.sv
design/ioRegs.sv
design/memoryMap.sv
design/hackTop.sv
test/hackTop_sva.sv
test/hackChecker.sv
test/hackTb.sv
